// ==== include/div_config.svh ====
`ifndef DIV_CONFIG_SVH
`define DIV_CONFIG_SVH

// ====================
// datapath
// ====================

`define DIV_XLEN 64  // one machine word

// ====================
// iteration
// ====================

`define DIV_FULL_STEPS 64  // div, divu, rem, remu
`define DIV_WORD_STEPS 32  // the *w variants

// step counter has to hold DIV_FULL_STEPS
`define DIV_CNT_W 7

`endif

// ==== rtl/div_pkg.sv ====
package div_pkg;

  localparam int unsigned DIV_OP_W    = 8;
  localparam int unsigned DIV_STATE_W = 2;

  // one-hot opcode as decoded by the core, bit 7 down to bit 0
  typedef enum logic [DIV_OP_W-1:0] {
    OP_NONE  = 8'b0000_0000,
    OP_REM   = 8'b1000_0000,  // signed, 64-bit
    OP_REMU  = 8'b0100_0000,  // unsigned, 64-bit
    OP_REMUW = 8'b0010_0000,  // unsigned, word
    OP_REMW  = 8'b0001_0000,  // signed, word
    OP_DIV   = 8'b0000_1000,
    OP_DIVU  = 8'b0000_0100,
    OP_DIVUW = 8'b0000_0010,
    OP_DIVW  = 8'b0000_0001
  } div_op_e;

  // divider control FSM
  typedef enum logic [DIV_STATE_W-1:0] {
    ST_IDLE = 2'd0,  // waiting for div_valid_i
    ST_ITER = 2'd1,  // one quotient bit per cycle
    ST_DONE = 2'd2   // result held until result_ready_i
  } div_state_e;

endpackage

// ==== rtl/div_operand_if.sv ====
`timescale 1ns/1ps
`include "div_config.svh"

interface div_operand_if
  import div_pkg::*;
();

  logic                 start;         // decoded div_valid_i
  div_op_e              op;
  logic                 word;          // 32-bit op
  logic [`DIV_XLEN-1:0] dividend_abs;  // zero-extended low word for word ops
  logic [`DIV_XLEN-1:0] divisor_abs;
  logic                 quot_neg;
  logic                 rem_neg;
  logic                 exc_valid;     // divide by zero or signed overflow
  logic [`DIV_XLEN-1:0] exc_result;

  // ====================
  // operand producer
  // ====================
  modport prep (
    output start, op, word, dividend_abs, divisor_abs,
    output quot_neg, rem_neg, exc_valid, exc_result
  );

  // iteration side
  modport core (
    input start, op, word, dividend_abs, divisor_abs,
    input quot_neg, rem_neg, exc_valid, exc_result
  );

endinterface

// ==== rtl/div_operand_prep.sv ====
`timescale 1ns/1ps
`include "div_config.svh"

module div_operand_prep
  import div_pkg::*;
(
  input  logic                 div_valid_i,
  input  logic [7:0]           div_type_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  div_operand_if.prep          opnd
);

  localparam int unsigned XLEN = `DIV_XLEN;
  localparam int unsigned HALF = XLEN / 2;

  localparam logic [7:0] WORD_MASK   = OP_REMUW | OP_REMW | OP_DIVUW | OP_DIVW;
  localparam logic [7:0] SIGNED_MASK = OP_REM | OP_REMW | OP_DIV | OP_DIVW;
  localparam logic [7:0] REM_MASK    = OP_REM | OP_REMU | OP_REMUW | OP_REMW;

  logic            is_word;
  logic            is_signed;
  logic            is_rem;
  logic            dvd_neg;
  logic            dvs_neg;
  logic [HALF-1:0] dvd_lo_abs;
  logic [HALF-1:0] dvs_lo_abs;
  logic [XLEN-1:0] dvd_full_abs;
  logic [XLEN-1:0] dvs_full_abs;
  logic [XLEN-1:0] dividend_arch;  // dividend as the ISA sees it
  logic            div_zero;
  logic            div_ovf;

  // ====================
  // opcode decode
  // ====================
  assign is_word   = |(div_type_i & WORD_MASK);
  assign is_signed = |(div_type_i & SIGNED_MASK);
  assign is_rem    = |(div_type_i & REM_MASK);

  // operand signs, zero for unsigned ops
  assign dvd_neg = is_signed & (is_word ? dividend_i[HALF-1] : dividend_i[XLEN-1]);
  assign dvs_neg = is_signed & (is_word ? divisor_i[HALF-1] : divisor_i[XLEN-1]);

  // magnitudes, min value keeps its bit pattern as unsigned
  assign dvd_lo_abs   = dvd_neg ? -dividend_i[HALF-1:0] : dividend_i[HALF-1:0];
  assign dvs_lo_abs   = dvs_neg ? -divisor_i[HALF-1:0] : divisor_i[HALF-1:0];
  assign dvd_full_abs = dvd_neg ? -dividend_i : dividend_i;
  assign dvs_full_abs = dvs_neg ? -divisor_i : divisor_i;

  assign dividend_arch = is_word ? {{HALF{dividend_i[HALF-1]}}, dividend_i[HALF-1:0]}
                                 : dividend_i;

  // ====================
  // exception detect
  // ====================
  // word ops only look at the low word
  assign div_zero = is_word ? ~|divisor_i[HALF-1:0] : ~|divisor_i;

  always_comb begin
    div_ovf = 1'b0;
    if (is_signed) begin
      if (is_word) begin
        div_ovf = (dividend_i[HALF-1:0] == {1'b1, {(HALF-1){1'b0}}}) &&
                  (&divisor_i[HALF-1:0]);
      end else begin
        div_ovf = (dividend_i == {1'b1, {(XLEN-1){1'b0}}}) && (&divisor_i);
      end
    end
  end

  always_comb begin
    opnd.exc_result = '0;
    if (div_zero) begin
      opnd.exc_result = is_rem ? dividend_arch : '1;  // q = -1, r = dividend
    end else if (div_ovf) begin
      opnd.exc_result = is_rem ? '0 : dividend_arch;  // q = dividend, r = 0
    end
  end

  assign opnd.start        = div_valid_i;
  assign opnd.op           = div_op_e'(div_type_i);
  assign opnd.word         = is_word;
  assign opnd.dividend_abs = is_word ? {{HALF{1'b0}}, dvd_lo_abs} : dvd_full_abs;
  assign opnd.divisor_abs  = is_word ? {{HALF{1'b0}}, dvs_lo_abs} : dvs_full_abs;
  assign opnd.quot_neg     = dvd_neg ^ dvs_neg;
  assign opnd.rem_neg      = dvd_neg;  // remainder follows the dividend
  assign opnd.exc_valid    = div_zero | div_ovf;

  // requests carry exactly one opcode bit
  always_comb begin
    if (div_valid_i) begin
      a_type_onehot: assert final ($onehot(div_type_i))
        else $error("div_type_i not one-hot on a request: %b", div_type_i);
    end
  end

endmodule

// ==== rtl/div_iter_core.sv ====
`timescale 1ns/1ps
`include "div_config.svh"

module div_iter_core
  import div_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  div_operand_if.core          opnd,
  input  logic                 result_ready_i,
  output logic [`DIV_XLEN-1:0] div_out_o,
  output logic                 div_stall_o,
  output logic                 result_ok_o
);

  localparam int unsigned XLEN = `DIV_XLEN;
  localparam int unsigned HALF = XLEN / 2;

  div_state_e            state_q;
  div_state_e            state_d;
  logic [`DIV_CNT_W-1:0] cnt_q;         // steps left in ST_ITER
  logic [2*XLEN-1:0]     rq_q;          // remainder high, quotient low
  logic [XLEN-1:0]       divisor_q;
  div_op_e               op_q;
  logic                  word_q;
  logic                  quot_neg_q;
  logic                  rem_neg_q;
  logic                  exc_q;
  logic [XLEN-1:0]       exc_result_q;

  logic                  accept;
  logic [XLEN:0]         trial;         // bit XLEN set means it went negative
  logic [XLEN-1:0]       quot_fix;
  logic [XLEN-1:0]       rem_fix;
  logic [XLEN-1:0]       res_raw;
  logic [XLEN-1:0]       res_word;

  assign accept = (state_q == ST_IDLE) && opnd.start;

  // ====================
  // control FSM
  // ====================
  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = opnd.exc_valid ? ST_DONE : ST_ITER;  // exceptions skip the loop
        end
      end
      ST_ITER: begin
        if (cnt_q == `DIV_CNT_W'(1)) begin
          state_d = ST_DONE;
        end
      end
      ST_DONE: begin
        if (result_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        cnt_q <= opnd.word ? `DIV_CNT_W'(`DIV_WORD_STEPS) : `DIV_CNT_W'(`DIV_FULL_STEPS);
      end else if (state_q == ST_ITER) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // ====================
  // restoring iteration
  // ====================
  // shifted remainder fits in XLEN+1 bits
  assign trial = rq_q[2*XLEN-1:XLEN-1] - {1'b0, divisor_q};

  always_ff @(posedge clk) begin
    if (accept) begin
      op_q         <= opnd.op;
      word_q       <= opnd.word;
      quot_neg_q   <= opnd.quot_neg;
      rem_neg_q    <= opnd.rem_neg;
      exc_q        <= opnd.exc_valid;
      exc_result_q <= opnd.exc_result;
      divisor_q    <= opnd.divisor_abs;
      if (opnd.word) begin
        // left-aligned so 32 shifts consume the low word
        rq_q <= {{XLEN{1'b0}}, opnd.dividend_abs[HALF-1:0], {HALF{1'b0}}};
      end else begin
        rq_q <= {{XLEN{1'b0}}, opnd.dividend_abs};
      end
    end else if (state_q == ST_ITER) begin
      if (trial[XLEN]) begin
        rq_q <= {rq_q[2*XLEN-2:0], 1'b0};  // restore, quotient bit 0
      end else begin
        rq_q <= {trial[XLEN-1:0], rq_q[XLEN-2:0], 1'b1};
      end
    end
  end

  // ====================
  // sign fix and result
  // ====================
  assign quot_fix = quot_neg_q ? -rq_q[XLEN-1:0] : rq_q[XLEN-1:0];
  assign rem_fix  = rem_neg_q ? -rq_q[2*XLEN-1:XLEN] : rq_q[2*XLEN-1:XLEN];

  always_comb begin
    case (op_q)
      OP_REM, OP_REMU, OP_REMUW, OP_REMW: res_raw = rem_fix;
      default:                            res_raw = quot_fix;
    endcase
  end

  assign res_word = {{HALF{res_raw[HALF-1]}}, res_raw[HALF-1:0]};

  always_comb begin
    if (state_q != ST_DONE) begin
      div_out_o = '0;
    end else if (exc_q) begin
      div_out_o = exc_result_q;
    end else begin
      div_out_o = word_q ? res_word : res_raw;
    end
  end

  assign div_stall_o = (accept && !opnd.exc_valid) || (state_q == ST_ITER);
  assign result_ok_o = (state_q == ST_DONE);

  a_stall_ok_excl: assert property (@(posedge clk) disable iff (rst_n)
    !(div_stall_o && result_ok_o))
    else $error("div_stall_o and result_ok_o high together");

  a_ok_low_after_reset: assert property (@(posedge clk) rst_n |=> !result_ok_o)
    else $error("result_ok_o high right after reset");

  a_cnt_no_underflow: assert property (@(posedge clk) disable iff (rst_n)
    (state_q == ST_ITER) |-> (cnt_q != '0))
    else $error("step counter empty while iterating");

endmodule

// ==== rtl/rv_divider.sv ====
`timescale 1ns/1ps
`include "div_config.svh"

module rv_divider (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 div_valid_i,
  input  logic [7:0]           div_type_i,
  input  logic [`DIV_XLEN-1:0] dividend_i,
  input  logic [`DIV_XLEN-1:0] divisor_i,
  input  logic                 result_ready_i,
  output logic [`DIV_XLEN-1:0] div_out_o,
  output logic                 div_stall_o,
  output logic                 result_ok_o
);

  // ====================
  // operand path
  // ====================
  div_operand_if opnd_if ();

  // combinational decode and exception detect
  div_operand_prep u_prep (
    .div_valid_i (div_valid_i),
    .div_type_i  (div_type_i),
    .dividend_i  (dividend_i),
    .divisor_i   (divisor_i),
    .opnd        (opnd_if.prep)
  );

  // sequential divide, one bit per cycle
  div_iter_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .opnd           (opnd_if.core),
    .result_ready_i (result_ready_i),
    .div_out_o      (div_out_o),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

endmodule

// ==== dv/rv_divider_tb.sv ====
`timescale 1ns/1ps
`include "div_config.svh"

module rv_divider_tb
  import div_pkg::*;
();

  localparam int unsigned N_DIRECTED  = 40;   // upper bound on directed and control ops
  localparam int unsigned N_RANDOM    = 300;
  localparam int unsigned N_OPS       = N_DIRECTED + N_RANDOM;
  localparam int unsigned CLK_PERIOD  = 40;
  localparam int unsigned WATCHDOG_NS = (N_OPS * 70 + 200) * CLK_PERIOD;
  localparam logic [31:0] LFSR_SEED   = 32'hfae32ae4;
  localparam logic [63:0] MIN64       = 64'h8000_0000_0000_0000;

  logic                 clk;
  logic                 rst_n;
  logic                 div_valid_i;
  logic [7:0]           div_type_i;
  logic [`DIV_XLEN-1:0] dividend_i;
  logic [`DIV_XLEN-1:0] divisor_i;
  logic                 result_ready_i;
  logic [`DIV_XLEN-1:0] div_out_o;
  logic                 div_stall_o;
  logic                 result_ok_o;

  logic [31:0]          lfsr_state;
  string                name_q[$];    // pending requests in issue order
  logic [63:0]          exp_q[$];
  int                   n_issued;
  int                   n_done;
  int                   n_errors;

  rv_divider dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_type_i     (div_type_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .div_out_o      (div_out_o),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // ====================
  // helpers
  // ====================
  // taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [63:0] ref_div(input div_op_e op, input logic [63:0] a,
                                          input logic [63:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [31:0] sa32;
    logic signed [31:0] sb32;
    logic signed [63:0] quo64;
    logic signed [63:0] rem64;
    logic signed [31:0] quo32;
    logic signed [31:0] rem32;
    logic [31:0]        ua32;
    logic [31:0]        ub32;
    logic [31:0]        r32;
    logic [63:0]        r;
    logic               ovf64;
    logic               ovf32;
    sa    = a;
    sb    = b;
    sa32  = a[31:0];
    sb32  = b[31:0];
    ua32  = a[31:0];
    ub32  = b[31:0];
    quo64 = sa / sb;  // signed, truncating toward zero
    rem64 = sa % sb;
    quo32 = sa32 / sb32;
    rem32 = sa32 % sb32;
    ovf64 = (a == MIN64) && (b == '1);
    ovf32 = (ua32 == 32'h8000_0000) && (ub32 == '1);
    r     = '0;
    r32   = '0;
    case (op)
      OP_DIV:   r = (b == 0) ? '1 : (ovf64 ? a : quo64);
      OP_REM:   r = (b == 0) ? a : (ovf64 ? '0 : rem64);
      OP_DIVU:  r = (b == 0) ? '1 : a / b;
      OP_REMU:  r = (b == 0) ? a : a % b;
      OP_DIVW:  r32 = (ub32 == 0) ? '1 : (ovf32 ? ua32 : quo32);
      OP_REMW:  r32 = (ub32 == 0) ? ua32 : (ovf32 ? '0 : rem32);
      OP_DIVUW: r32 = (ub32 == 0) ? '1 : ua32 / ub32;
      OP_REMUW: r32 = (ub32 == 0) ? ua32 : ua32 % ub32;
      default:  r = '0;
    endcase
    if (op inside {OP_DIVW, OP_REMW, OP_DIVUW, OP_REMUW}) begin
      r = {{32{r32[31]}}, r32};  // word results sign-extend from bit 31
    end
    return r;
  endfunction

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      n_errors++;
    end
  endtask

  // one-cycle request pulse that returns on the negedge after the accepting edge
  task automatic issue(input string name, input div_op_e op, input logic [63:0] a,
                       input logic [63:0] b);
    @(negedge clk);
    div_valid_i = 1'b1;
    div_type_i  = op;
    dividend_i  = a;
    divisor_i   = b;
    name_q.push_back(name);
    exp_q.push_back(ref_div(op, a, b));
    n_issued++;
    @(negedge clk);
    div_valid_i = 1'b0;
  endtask

  task automatic wait_done();
    while (n_done < n_issued) @(negedge clk);
  endtask

  task automatic run_op(input string name, input div_op_e op, input logic [63:0] a,
                        input logic [63:0] b);
    issue(name, op, a, b);
    wait_done();
  endtask

  // latency counts the accepting edge as the first
  task automatic timed_op(input string name, input div_op_e op, input logic [63:0] a,
                          input logic [63:0] b, input int exp_lat);
    int lat;
    issue(name, op, a, b);
    lat = 1;
    while (!result_ok_o) begin
      check({name, "_stall"}, 64'd1, div_stall_o);
      @(negedge clk);
      lat++;
    end
    check({name, "_latency"}, exp_lat, lat);
    wait_done();
  endtask

  // ====================
  // compare process
  // ====================
  // result is consumed on the edge where ok and ready are both high
  always @(posedge clk) begin
    if (!rst_n && result_ok_o && result_ready_i) begin
      if (exp_q.size() == 0) begin
        $display("result_ok_o came with no request outstanding");
        n_errors++;
      end else begin
        check(name_q.pop_front(), exp_q.pop_front(), div_out_o);
      end
      n_done++;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired: result_ok_o never came after %0d requests", n_issued);
    $display("Test failed");
    $finish;
  end

  // ====================
  // stimulus
  // ====================
  initial begin
    div_op_e     op;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] held;
    int          hold_cycles;
    int          k;
    lfsr_state     = LFSR_SEED;
    rst_n          = 1'b1;
    div_valid_i    = 1'b0;
    div_type_i     = OP_NONE;
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b1;
    n_issued       = 0;
    n_done         = 0;
    n_errors       = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;
    @(negedge clk);
    check("reset_ok", 64'd0, result_ok_o);
    check("reset_stall", 64'd0, div_stall_o);
    check("reset_out", 64'd0, div_out_o);

    // sign table
    run_op("div_pp", OP_DIV, 64'd20, 64'd6);
    run_op("rem_pp", OP_REM, 64'd20, 64'd6);
    run_op("divu_pp", OP_DIVU, 64'd1000, 64'd7);
    run_op("remu_pp", OP_REMU, 64'd1000, 64'd7);
    run_op("div_np", OP_DIV, -64'd20, 64'd6);
    run_op("rem_np", OP_REM, -64'd20, 64'd6);   // negative remainder
    run_op("div_pn", OP_DIV, 64'd20, -64'd6);
    run_op("rem_pn", OP_REM, 64'd20, -64'd6);
    run_op("div_nn", OP_DIV, -64'd20, -64'd6);
    run_op("rem_nn", OP_REM, -64'd20, -64'd6);
    run_op("divu_big", OP_DIVU, 64'hffff_ffff_ffff_fff0, 64'd3);
    run_op("divw_np", OP_DIVW, 64'h0000_0000_ffff_ff9c, 64'd7);
    run_op("remw_np", OP_REMW, 64'h0000_0000_ffff_ff9c, 64'd7);
    run_op("divuw_pp", OP_DIVUW, 64'd99, 64'd10);
    run_op("remuw_pp", OP_REMUW, 64'd99, 64'd10);

    // divide by zero (word ops see only the low half of the divisor)
    run_op("div_zero", OP_DIV, -64'd5, 64'd0);
    run_op("rem_zero", OP_REM, -64'd5, 64'd0);
    run_op("divu_zero", OP_DIVU, 64'd77, 64'd0);
    run_op("remu_zero", OP_REMU, 64'd77, 64'd0);
    run_op("divw_zero", OP_DIVW, 64'h1234_5678_8765_4321, 64'hffff_ffff_0000_0000);
    run_op("remw_zero", OP_REMW, 64'h1234_5678_8765_4321, 64'hffff_ffff_0000_0000);
    run_op("divuw_zero", OP_DIVUW, 64'h0000_0001_0000_0042, 64'h0000_0001_0000_0000);
    run_op("remuw_zero", OP_REMUW, 64'h0000_0001_9000_0042, 64'h0000_0001_0000_0000);

    // signed overflow
    run_op("div_ovf", OP_DIV, MIN64, '1);
    run_op("rem_ovf", OP_REM, MIN64, '1);
    run_op("divw_ovf", OP_DIVW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);
    run_op("remw_ovf", OP_REMW, 64'h1234_5678_8000_0000, 64'h0000_0000_ffff_ffff);

    // upper operand bits ignored by word ops
    run_op("divw_upper", OP_DIVW, 64'hdead_beef_0000_0064, 64'h1111_1111_0000_0007);
    run_op("remw_upper", OP_REMW, 64'hdead_beef_0000_0064, 64'h1111_1111_0000_0007);
    run_op("divuw_bit31", OP_DIVUW, 64'h5555_0000_ffff_fff0, 64'd1);
    run_op("remuw_bit31", OP_REMUW, 64'h0000_0000_9000_0000, 64'h0000_0000_f000_0000);

    // exact latency
    timed_op("lat_full", OP_DIVU, 64'h0123_4567_89ab_cdef, 64'd13, `DIV_FULL_STEPS + 1);
    timed_op("lat_word", OP_REMW, 64'd12345, -64'd17, `DIV_WORD_STEPS + 1);
    timed_op("lat_exc", OP_DIV, 64'd9, 64'd0, 1);

    // ====================
    // back-pressure
    // ====================
    result_ready_i = 1'b0;
    issue("bp_hold", OP_DIV, -64'd1_000_003, 64'd41);
    while (!result_ok_o) @(negedge clk);
    held        = div_out_o;
    hold_cycles = rand_bits(4) + 3;
    for (k = 0; k < hold_cycles; k++) begin
      div_valid_i = (k == 1);  // ignored request mid-hold
      if (k == 1) begin
        div_type_i = OP_REMU;
        dividend_i = 64'd500;
        divisor_i  = 64'd7;
      end
      @(negedge clk);
      check("bp_ok", 64'd1, result_ok_o);
      check("bp_stall", 64'd0, div_stall_o);
      check("bp_out", held, div_out_o);
    end
    div_valid_i    = 1'b0;
    result_ready_i = 1'b1;
    wait_done();
    run_op("bp_next", OP_REMW, 64'hffff_ffff_8000_0001, 64'd3);

    // random regression
    for (k = 0; k < N_RANDOM; k++) begin
      op = div_op_e'(8'b1 << rand_bits(3));
      a  = rand_bits(64);
      case (rand_bits(2))
        2'd0:    b = rand_bits(64);
        2'd1:    b = rand_bits(12);
        2'd2:    b = -rand_bits(12);
        default: b = rand_bits(40);
      endcase
      run_op($sformatf("rand_%0d_%s", k, op.name()), op, a, b);
    end

    wait_done();
    repeat (2) @(negedge clk);
    $display("ops checked: %0d, errors: %0d", n_done, n_errors);
    if (n_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== rv_divider.f ====
+incdir+include
rtl/div_pkg.sv
rtl/div_operand_if.sv
rtl/div_operand_prep.sv
rtl/div_iter_core.sv
rtl/rv_divider.sv
dv/rv_divider_tb.sv
